/* execStage.f */
source/execPkg.sv
source/operandForward.sv
source/alu.sv
source/branchCond.sv
source/claAdder16.sv
source/execute.sv
source/exStage.sv
test/exChecker.sv
test/exStageTb.sv

/* runSim.sh */
#!/usr/bin/env bash
# build the execute stage testbench with Verilator, run it and scan the log
set -e
set -o pipefail

cd "$(dirname "$0")"
buildDir=build
mkdir -p "$buildDir"

verilator --binary --timing -sv --top-module exStageTb -Mdir "$buildDir/obj" -f execStage.f
"./$buildDir/obj/VexStageTb" | tee "$buildDir/sim.log"

if grep -qx "All tests passed" "$buildDir/sim.log"; then
   echo "simulation passed"
else
   echo "simulation failed"
   exit 1
fi

/* source/alu.sv */
// 16-bit ALU
// optional input inversion, carry in, shifts, rotates, logic ops and add
`timescale 1ns/1ps

module alu import execPkg::*; (
   input  word      a,
   input  word      b,
   input  aluOpE    op,
   input  logic     invA,
   input  logic     invB,
   input  logic     cin,
   output word      y,
   output aluFlagsS flags
);

   word                  aIn;
   word                  bIn;
   logic [3:0]           shAmt;
   logic [wordWidth:0]   sum;
   logic [2*wordWidth-1:0] rotL;
   logic [2*wordWidth-1:0] rotR;

   assign aIn   = invA ? ~a : a;
   assign bIn   = invB ? ~b : b;
   assign shAmt = b[3:0];

   // add path, also the subtract path with invB and cin set
   assign sum = {1'b0, aIn} + {1'b0, bIn} + {{wordWidth{1'b0}}, cin};

   // doubled word so a plain shift wraps the bits around
   assign rotL = {aIn, aIn} << shAmt;
   assign rotR = {aIn, aIn} >> shAmt;

   always_comb begin
      case (op)
         aluRol:   y = rotL[2*wordWidth-1:wordWidth];
         aluSll:   y = aIn << shAmt;
         aluRor:   y = rotR[wordWidth-1:0];
         aluSrl:   y = aIn >> shAmt;
         aluAdd:   y = sum[wordWidth-1:0];
         aluAnd:   y = aIn & bIn;
         aluOr:    y = aIn | bIn;
         aluXor:   y = aIn ^ bIn;
         aluPassB: y = bIn;
         default:  y = '0;
      endcase
   end

   // carry and signed overflow always come from the adder
   assign flags.carry    = sum[wordWidth];
   assign flags.overflow = (aIn[wordWidth-1] == bIn[wordWidth-1]) &&
                           (sum[wordWidth-1] != aIn[wordWidth-1]);

   // zero and sign follow the selected result
   assign flags.zero = (y == '0);
   assign flags.sign = y[wordWidth-1];

endmodule

/* source/branchCond.sv */
// branch and set condition
// turns the condition code and ALU flags into a jump or set bit
`timescale 1ns/1ps

module branchCond import execPkg::*; (
   input  brchCondE cond,
   input  aluFlagsS flags,
   output logic     take
);

   logic lessThan;

   // signed compare of the subtract result
   assign lessThan = flags.sign ^ flags.overflow;

   always_comb begin
      case (cond)
         condEqz: take = flags.zero;
         condNez: take = ~flags.zero;
         condLtz: take = flags.sign;
         condGez: take = ~flags.sign;
         condSlt: take = lessThan;
         condSle: take = lessThan | flags.zero;
         condSco: take = flags.carry;
         default: take = 1'b0;   // never
      endcase
   end

endmodule

/* source/claAdder16.sv */
// 16-bit carry-lookahead adder
// four nibble groups with a second lookahead level, carry in is zero
`timescale 1ns/1ps

module claAdder16 import execPkg::*; (
   input  word a,
   input  word b,
   output word sum
);

   word                    g;
   word                    p;
   word                    c;
   logic [nibbleCount-1:0] grpG;
   logic [nibbleCount-1:0] grpP;
   logic [nibbleCount-1:0] grpC;

   assign g = a & b;
   assign p = a ^ b;

   // second level, carry into each nibble
   assign grpC[0] = 1'b0;
   assign grpC[1] = grpG[0];
   assign grpC[2] = grpG[1] | (grpP[1] & grpG[0]);
   assign grpC[3] = grpG[2] | (grpP[2] & grpG[1]) | (grpP[2] & grpP[1] & grpG[0]);

   for (genvar k = 0; k < nibbleCount; k++) begin : gNibble
      localparam int base = 4 * k;
      logic [3:0] ng;
      logic [3:0] np;
      assign ng = g[base+3:base];
      assign np = p[base+3:base];
      // group generate and propagate for the second level
      assign grpG[k] = ng[3] | (np[3] & ng[2]) | (np[3] & np[2] & ng[1]) |
                       (np[3] & np[2] & np[1] & ng[0]);
      assign grpP[k] = &np;
      // carries inside the nibble
      assign c[base]   = grpC[k];
      assign c[base+1] = ng[0] | (np[0] & grpC[k]);
      assign c[base+2] = ng[1] | (np[1] & ng[0]) | (np[1] & np[0] & grpC[k]);
      assign c[base+3] = ng[2] | (np[2] & ng[1]) | (np[2] & np[1] & ng[0]) |
                         (np[2] & np[1] & np[0] & grpC[k]);
   end

   assign sum = p ^ c;

endmodule

/* source/exStage.sv */
// execute stage top
// combinational execute followed by the ex/mem register with stall hold
`timescale 1ns/1ps

module exStage import execPkg::*; (
   input  logic     clk,
   input  logic     arstN,
   input  logic     inValid,
   input  logic     stall,
   input  exCtrlS   ctrl,
   input  word      inA,
   input  word      inB,
   input  word      incPc,
   input  word      imm8,
   input  word      imm11,
   input  fwdSelS   fwdSelA,
   input  fwdSelS   fwdSelB,
   input  storeSelS storeSel,
   input  word      storeIn,
   input  fwdBusS   fwd,
   output logic     outValid,
   output exResultS outResult
);

   exResultS result;

   execute i_execute (
      .ctrl     (ctrl),
      .inA      (inA),
      .inB      (inB),
      .incPc    (incPc),
      .imm8     (imm8),
      .imm11    (imm11),
      .storeIn  (storeIn),
      .fwdSelA  (fwdSelA),
      .fwdSelB  (fwdSelB),
      .storeSel (storeSel),
      .fwd      (fwd),
      .result   (result)
   );

   // stall holds the latch, the vector offered that cycle is dropped
   always_ff @(posedge clk or negedge arstN) begin
      if (!arstN) begin
         outValid  <= 1'b0;
         outResult <= '0;
      end else if (!stall) begin
         outValid  <= inValid;
         outResult <= result;
      end
   end

endmodule

/* source/execPkg.sv */
// execute stage package
// word type, ALU and condition codes, forwarding selects and stage structs

package execPkg;

   localparam int wordWidth = 16;
   localparam int nibbleCount = wordWidth / 4;

   typedef logic [wordWidth-1:0] word;

   // ALU operations, passB serves load-immediate style moves
   typedef enum logic [3:0] {
      aluRol   = 4'h0,
      aluSll   = 4'h1,
      aluRor   = 4'h2,
      aluSrl   = 4'h3,
      aluAdd   = 4'h4,
      aluAnd   = 4'h5,
      aluOr    = 4'h6,
      aluXor   = 4'h7,
      aluPassB = 4'h8
   } aluOpE;

   // branch conditions first, then set conditions on a subtract
   typedef enum logic [2:0] {
      condNever = 3'd0,
      condEqz   = 3'd1,
      condNez   = 3'd2,
      condLtz   = 3'd3,
      condGez   = 3'd4,
      condSlt   = 3'd5,
      condSle   = 3'd6,
      condSco   = 3'd7
   } brchCondE;

   typedef enum logic [1:0] {
      srcLinkPc = 2'b00,
      srcMem    = 2'b01,
      srcAlu    = 2'b10,
      srcImm8   = 2'b11
   } fwdSrcE;

   typedef struct packed {
      logic   enable;
      logic   fromMem;   // 0 ex/mem latch, 1 mem/wb latch
      fwdSrcE src;
   } fwdSelS;

   typedef struct packed {
      logic isStore;
      logic swapOrder;
   } storeSelS;

   typedef struct packed {
      word x2xAlu;
      word x2xImm8;
      word x2xLinkPc;
      word m2xAlu;
      word m2xImm8;
      word m2xMem;
      word m2xLinkPc;
   } fwdBusS;

   typedef struct packed {
      aluOpE    aluOp;
      logic     invA;
      logic     invB;
      logic     cin;
      brchCondE brchCond;
      logic     immSrc;    // 1 picks imm11
      logic     aluPc;     // target base is aluOut
      logic     aluJmp;
      logic     jalSel;
      logic     setOpSel;
      logic     slbiSel;
      logic     stuSel;
   } exCtrlS;

   typedef struct packed {
      logic zero;
      logic overflow;
      logic carry;
      logic sign;
   } aluFlagsS;

   typedef struct packed {
      word aluFinal;
      word newPc;
      word linkPc;
      word storeData;
   } exResultS;

endpackage

/* source/execute.sv */
// execute stage, combinational
// forwarding, ALU, condition, target adder and the pc selection
`timescale 1ns/1ps

module execute import execPkg::*; (
   input  exCtrlS   ctrl,
   input  word      inA,
   input  word      inB,
   input  word      incPc,
   input  word      imm8,
   input  word      imm11,
   input  word      storeIn,
   input  fwdSelS   fwdSelA,
   input  fwdSelS   fwdSelB,
   input  storeSelS storeSel,
   input  fwdBusS   fwd,
   output exResultS result
);

   word      opA;
   word      opB;
   word      storeData;
   word      aluOut;
   aluFlagsS flags;
   logic     takeJump;
   word      pcBase;
   word      immOff;
   word      target;
   word      jmpPc;

   operandForward i_operandForward (
      .inA       (inA),
      .inB       (inB),
      .storeIn   (storeIn),
      .fwdSelA   (fwdSelA),
      .fwdSelB   (fwdSelB),
      .storeSel  (storeSel),
      .stuSel    (ctrl.stuSel),
      .fwd       (fwd),
      .opA       (opA),
      .opB       (opB),
      .storeData (storeData)
   );

   alu i_alu (
      .a     (opA),
      .b     (opB),
      .op    (ctrl.aluOp),
      .invA  (ctrl.invA),
      .invB  (ctrl.invB),
      .cin   (ctrl.cin),
      .y     (aluOut),
      .flags (flags)
   );

   branchCond i_branchCond (
      .cond  (ctrl.brchCond),
      .flags (flags),
      .take  (takeJump)
   );

   // register-relative target when aluPc is set, pc-relative otherwise
   assign pcBase = ctrl.aluPc ? aluOut : incPc;
   assign immOff = ctrl.immSrc ? imm11 : imm8;

   claAdder16 i_claAdder16 (
      .a   (pcBase),
      .b   (immOff),
      .sum (target)
   );

   assign jmpPc = takeJump ? target : incPc;

   // slbi wins over everything, then jump-register
   assign result.newPc     = ctrl.slbiSel ? incPc : (ctrl.aluJmp ? aluOut : jmpPc);
   assign result.linkPc    = ctrl.jalSel ? incPc : jmpPc;
   assign result.aluFinal  = ctrl.setOpSel ? {{(wordWidth-1){1'b0}}, takeJump} : aluOut;
   assign result.storeData = storeData;

endmodule

/* source/operandForward.sv */
// operand forwarding
// picks A, B and store data from register values or the forwarding bus
`timescale 1ns/1ps

module operandForward import execPkg::*; (
   input  word      inA,
   input  word      inB,
   input  word      storeIn,
   input  fwdSelS   fwdSelA,
   input  fwdSelS   fwdSelB,
   input  storeSelS storeSel,
   input  logic     stuSel,
   input  fwdBusS   fwd,
   output word      opA,
   output word      opB,
   output word      storeData
);

   word fwdB;

   // one forwarding mux, shared by both operands
   function automatic word pickOperand(input fwdSelS sel, input word regVal, input fwdBusS bus);
      word pick;
      pick = regVal;
      if (sel.enable) begin
         if (sel.fromMem) begin
            case (sel.src)
               srcLinkPc: pick = bus.m2xLinkPc;
               srcMem:    pick = bus.m2xMem;
               srcAlu:    pick = bus.m2xAlu;
               default:   pick = bus.m2xImm8;
            endcase
         end else begin
            // no memory word exists yet at ex/mem, memory falls back to link pc
            case (sel.src)
               srcAlu:  pick = bus.x2xAlu;
               srcImm8: pick = bus.x2xImm8;
               default: pick = bus.x2xLinkPc;
            endcase
         end
      end
      return pick;
   endfunction

   assign opA  = pickOperand(fwdSelA, inA, fwd);
   assign fwdB = pickOperand(fwdSelB, inB, fwd);

   // store with update keeps the raw register as the ALU operand
   assign opB = stuSel ? inB : fwdB;

   // swapOrder flips which source feeds the store data
   assign storeData = storeSel.isStore ? (storeSel.swapOrder ? storeIn : fwdB)
                                       : (storeSel.swapOrder ? fwdB : storeIn);

endmodule

/* test/exChecker.sv */
// execute stage checker
// compares the EX/MEM register with the expected columns and counts errors
`timescale 1ns/1ps

module exChecker import execPkg::*; (
   input  logic     clk,
   input  logic     arstN,
   input  logic     vecActive,
   input  int       vecIdx,
   input  logic     inValid,
   input  logic     stall,
   input  exResultS expResult,
   input  logic     outValid,
   input  exResultS outResult,
   input  logic     runDone,
   output int       errorCount
);

   int       errors     = 0;
   int       checkCount = 0;
   logic     started    = 1'b0;
   // vector offered at the coming edge and checked one negedge later
   logic     pending    = 1'b0;
   int       pendIdx    = 0;
   logic     pendValid  = 1'b0;
   logic     pendStall  = 1'b0;
   exResultS pendExp    = '0;
   // expected contents of the last vector the register took
   logic     lastValid  = 1'b0;
   exResultS lastExp    = '0;

   assign errorCount = errors;

   task automatic compareWord(input string where, input string name,
                              input word expVal, input word gotVal);
      checkCount++;
      if (gotVal !== expVal) begin
         errors++;
         $display("Error at %0d ns: %s %s expected %h got %h",
                  $time, where, name, expVal, gotVal);
      end
   endtask

   task automatic compareResult(input string where, input exResultS expVal);
      compareWord(where, "outResult.aluFinal", expVal.aluFinal, outResult.aluFinal);
      compareWord(where, "outResult.newPc", expVal.newPc, outResult.newPc);
      compareWord(where, "outResult.linkPc", expVal.linkPc, outResult.linkPc);
      compareWord(where, "outResult.storeData", expVal.storeData, outResult.storeData);
   endtask

   // negedge keeps sampling away from the rising edge and the 1 ns drive
   always @(negedge clk) begin
      if (pending) begin
         if (pendStall) begin
            // stalled edge leaves the register as it was
            compareWord($sformatf("vector %0d", pendIdx), "outValid",
                        word'(lastValid), word'(outValid));
            compareResult($sformatf("vector %0d", pendIdx), lastExp);
         end else begin
            compareWord($sformatf("vector %0d", pendIdx), "outValid",
                        word'(pendValid), word'(outValid));
            if (pendValid) begin
               compareResult($sformatf("vector %0d", pendIdx), pendExp);
            end
            // the register takes the result even for an invalid vector
            lastValid = pendValid;
            lastExp   = pendExp;
         end
      end else if (!started) begin
         // reset and idle cycles before the first vector
         compareWord("reset", "outValid", '0, word'(outValid));
         compareResult("reset", '0);
      end
      pending    = vecActive && arstN;
      started    = started || vecActive;
      pendIdx    = vecIdx;
      pendValid  = inValid;
      pendStall  = stall;
      pendExp    = expResult;
   end

   initial begin
      @(posedge runDone);
      $display("checker: %0d checks, %0d errors", checkCount, errors);
   end

endmodule

/* test/exStageTb.sv */
// execute stage testbench
// reads the vector file, drives the EX/MEM stage and ends the run
`timescale 1ns/1ps

module exStageTb import execPkg::*; ();

   localparam int numVectors  = 32;
   localparam int vecWords    = 19;
   localparam int resetCycles = 16;
   localparam int clkPeriod   = 10;

   logic     clk;
   logic     arstN;
   logic     inValid;
   logic     stall;
   exCtrlS   ctrl;
   word      inA;
   word      inB;
   word      incPc;
   word      imm8;
   word      imm11;
   word      storeIn;
   fwdSelS   fwdSelA;
   fwdSelS   fwdSelB;
   storeSelS storeSel;
   fwdBusS   fwd;
   logic     outValid;
   exResultS outResult;
   exResultS expResult;
   int       vecIdx;
   logic     vecActive;
   logic     runDone;
   int       errorCount;
   // one line of the file fills vecWords words
   word      vecMem [0:numVectors*vecWords-1];

   exStage i_exStage (
      .clk       (clk),
      .arstN     (arstN),
      .inValid   (inValid),
      .stall     (stall),
      .ctrl      (ctrl),
      .inA       (inA),
      .inB       (inB),
      .incPc     (incPc),
      .imm8      (imm8),
      .imm11     (imm11),
      .fwdSelA   (fwdSelA),
      .fwdSelB   (fwdSelB),
      .storeSel  (storeSel),
      .storeIn   (storeIn),
      .fwd       (fwd),
      .outValid  (outValid),
      .outResult (outResult)
   );

   exChecker i_exChecker (
      .clk        (clk),
      .arstN      (arstN),
      .vecActive  (vecActive),
      .vecIdx     (vecIdx),
      .inValid    (inValid),
      .stall      (stall),
      .expResult  (expResult),
      .outValid   (outValid),
      .outResult  (outResult),
      .runDone    (runDone),
      .errorCount (errorCount)
   );

   initial begin
      clk = 1'b0;
      forever #(clkPeriod / 2) clk = ~clk;
   end

   // unpack one file line onto the DUT inputs and the expected result
   task automatic applyVector(input int idx);
      int  base;
      word ctl0;
      word ctl1;
      base = idx * vecWords;
      ctl0 = vecMem[base];
      ctl1 = vecMem[base+1];
      inValid            = ctl0[15];
      stall              = ctl0[14];
      storeSel.isStore   = ctl0[13];
      storeSel.swapOrder = ctl0[12];
      fwdSelA            = fwdSelS'(ctl0[11:8]);
      fwdSelB            = fwdSelS'(ctl0[7:4]);
      ctrl.setOpSel      = ctl0[3];
      ctrl.slbiSel       = ctl0[2];
      ctrl.stuSel        = ctl0[1];
      ctrl.aluOp         = aluOpE'(ctl1[15:12]);
      ctrl.invA          = ctl1[11];
      ctrl.invB          = ctl1[10];
      ctrl.cin           = ctl1[9];
      ctrl.brchCond      = brchCondE'(ctl1[6:4]);
      ctrl.immSrc        = ctl1[3];
      ctrl.aluPc         = ctl1[2];
      ctrl.aluJmp        = ctl1[1];
      ctrl.jalSel        = ctl1[0];
      inA     = vecMem[base+2];
      inB     = vecMem[base+3];
      incPc   = vecMem[base+4];
      imm8    = vecMem[base+5];
      imm11   = vecMem[base+6];
      storeIn = vecMem[base+7];
      // forwarding words in struct order
      fwd.x2xAlu    = vecMem[base+8];
      fwd.x2xImm8   = vecMem[base+9];
      fwd.x2xLinkPc = vecMem[base+10];
      fwd.m2xAlu    = vecMem[base+11];
      fwd.m2xImm8   = vecMem[base+12];
      fwd.m2xMem    = vecMem[base+13];
      fwd.m2xLinkPc = vecMem[base+14];
      expResult.aluFinal  = vecMem[base+15];
      expResult.newPc     = vecMem[base+16];
      expResult.linkPc    = vecMem[base+17];
      expResult.storeData = vecMem[base+18];
      vecIdx    = idx;
      vecActive = 1'b1;
   endtask

   initial begin
      arstN     = 1'b0;
      inValid   = 1'b0;
      stall     = 1'b0;
      ctrl      = '0;
      inA       = '0;
      inB       = '0;
      incPc     = '0;
      imm8      = '0;
      imm11     = '0;
      storeIn   = '0;
      fwdSelA   = '0;
      fwdSelB   = '0;
      storeSel  = '0;
      fwd       = '0;
      expResult = '0;
      vecIdx    = 0;
      vecActive = 1'b0;
      runDone   = 1'b0;
      $readmemh("test/exStage_testdata.hex", vecMem);
      repeat (resetCycles) @(posedge clk);
      #1 arstN = 1'b1;
      // one idle edge so the outputs are seen clear after release
      @(posedge clk);
      for (int i = 0; i < numVectors; i++) begin
         @(posedge clk);
         #1;
         applyVector(i);
      end
      @(posedge clk);
      #1;
      vecActive = 1'b0;
      inValid   = 1'b0;
      stall     = 1'b0;
      repeat (2) @(posedge clk);
      runDone = 1'b1;
      #1;
      if (errorCount == 0) begin
         $display("All tests passed");
      end else begin
         $display("Some tests failed");
      end
      $finish;
   end

   // watchdog, vectors plus reset plus margin
   initial begin
      #((numVectors + resetCycles + 20) * clkPeriod);
      $display("timeout: the run did not finish within %0d clock cycles",
               numVectors + resetCycles + 20);
      $display("Some tests failed");
      $finish;
   end

endmodule

/* test/exStage_testdata.hex */
// ctl0: valid stall isStore swapOrder | fwdSelA | fwdSelB | setOpSel slbiSel stuSel 0
// ctl1: aluOp | invA invB cin 0 | brchCond | immSrc aluPc aluJmp jalSel
// ctl0 ctl1 inA inB incPc imm8 imm11 storeIn fwd[7] aluFinal newPc linkPc storeData
8000 4200 1234 1111 0010 0004 0100 5a01 a001 a002 a003 b001 b002 b003 b004 2346 0010 0010 5a01
8000 4600 0050 0020 0012 0004 0100 5a02 a001 a002 a003 b001 b002 b003 b004 0030 0012 0012 5a02
8000 5000 f0f0 ff00 0014 0004 0100 5a03 a001 a002 a003 b001 b002 b003 b004 f000 0014 0014 5a03
8000 6000 1200 0034 0016 0004 0100 5a04 a001 a002 a003 b001 b002 b003 b004 1234 0016 0016 5a04
8000 7000 ffff 1234 0018 0004 0100 5a05 a001 a002 a003 b001 b002 b003 b004 edcb 0018 0018 5a05
8000 0000 8001 0004 001a 0004 0100 5a06 a001 a002 a003 b001 b002 b003 b004 0018 001a 001a 5a06
8000 2000 8001 0004 001c 0004 0100 5a07 a001 a002 a003 b001 b002 b003 b004 1800 001c 001c 5a07
8000 1000 00f1 0008 001e 0004 0100 5a08 a001 a002 a003 b001 b002 b003 b004 f100 001e 001e 5a08
8000 3000 8000 0013 0020 0004 0100 5a09 a001 a002 a003 b001 b002 b003 b004 1000 0020 0020 5a09
aab0 4000 1111 2222 0022 0004 0100 5a0a a001 a002 a003 b001 b002 b003 b004 4003 0022 0022 a002
b8e0 4000 1111 2222 0024 0004 0100 5a0b a001 a002 a003 b001 b002 b003 b004 5004 0024 0024 5a0b
9fd0 4000 1111 2222 0026 0004 0100 5a0c a001 a002 a003 b001 b002 b003 b004 6005 0026 0026 b003
aca2 4000 1111 0100 0028 0004 0100 5a0d a001 a002 a003 b001 b002 b003 b004 b104 0028 0028 a001
8000 4010 0000 0000 0100 0010 0200 5a10 a001 a002 a003 b001 b002 b003 b004 0000 0110 0110 5a10
8000 4010 0001 0000 0102 0010 0200 5a11 a001 a002 a003 b001 b002 b003 b004 0001 0102 0102 5a11
8000 4028 0003 0000 0104 0010 0200 5a12 a001 a002 a003 b001 b002 b003 b004 0003 0304 0304 5a12
8000 4020 0000 0000 0106 0010 0200 5a13 a001 a002 a003 b001 b002 b003 b004 0000 0106 0106 5a13
8000 4031 8000 0000 0108 fff0 0200 5a14 a001 a002 a003 b001 b002 b003 b004 8000 00f8 0108 5a14
8000 4030 7fff 0000 010a 0010 0200 5a15 a001 a002 a003 b001 b002 b003 b004 7fff 010a 010a 5a15
8000 4044 0400 0000 010c 0010 0200 5a16 a001 a002 a003 b001 b002 b003 b004 0400 0410 0410 5a16
8000 4040 ffff 0000 010e 0010 0200 5a17 a001 a002 a003 b001 b002 b003 b004 ffff 010e 010e 5a17
8004 4040 0001 0000 0110 0010 0200 5a18 a001 a002 a003 b001 b002 b003 b004 0001 0110 0120 5a18
8008 4650 0003 0005 0200 0000 0000 5a20 a001 a002 a003 b001 b002 b003 b004 0001 0200 0200 5a20
8008 4650 7fff ffff 0202 0000 0000 5a21 a001 a002 a003 b001 b002 b003 b004 0000 0202 0202 5a21
8008 4660 0009 0009 0204 0000 0000 5a22 a001 a002 a003 b001 b002 b003 b004 0001 0204 0204 5a22
8008 4660 000a 0009 0206 0000 0000 5a23 a001 a002 a003 b001 b002 b003 b004 0000 0206 0206 5a23
8008 4670 0005 0003 0208 0000 0000 5a24 a001 a002 a003 b001 b002 b003 b004 0001 0208 0208 5a24
8008 4670 0003 0005 020a 0000 0000 5a25 a001 a002 a003 b001 b002 b003 b004 0000 020a 020a 5a25
8000 8003 1111 0340 0300 0004 0100 5a30 a001 a002 a003 b001 b002 b003 b004 0340 0340 0300 5a30
c000 4000 7777 1111 0400 0004 0100 5a40 a001 a002 a003 b001 b002 b003 b004 8888 0400 0400 5a40
0000 4000 0001 0001 0402 0004 0100 5a41 a001 a002 a003 b001 b002 b003 b004 0002 0402 0402 5a41
8000 7000 ffff 0f0f 0404 0004 0100 5a42 a001 a002 a003 b001 b002 b003 b004 f0f0 0404 0404 5a42
